// File: Bender.yml
package:
  name: uart_cmd_top

sources:
  - design/uart_cmd_pkg.sv
  - design/uart_rx.sv
  - design/cmd_assembler.sv
  - design/reg_engine.sv
  - design/uart_tx.sv
  - design/uart_cmd_top.sv
  - target: test
    files:
      - testbench/tb_uart_cmd_top.sv

// File: design/cmd_assembler.sv
`timescale 1ns/100ps

module cmd_assembler (
  input  logic               clk,
  input  logic               reset,
  input  logic [7:0]         rx_byte,
  input  logic               rx_req,
  output logic               rx_ack,
  output uart_cmd_pkg::cmd_t cmd,
  output logic               cmd_req,
  input  logic               cmd_ack
);

  import uart_cmd_pkg::*;

  typedef enum logic [2:0] {
    S_OP,       // Waiting for opcode byte
    S_DATA,     // Waiting for operand byte
    S_REL,      // Byte taken, waiting for req to drop
    S_ISSUE,
    S_CMD,      // Command presented
    S_CMD_REL
  } asm_state_e;

  asm_state_e state;
  cmd_op_e    byte_op;
  logic       need_data;
  logic       take_op;
  logic       take_data;

  assign byte_op   = cmd_op_e'(rx_byte[7:4]);
  assign take_op   = (state == S_OP) && rx_req;
  assign take_data = (state == S_DATA) && rx_req;

  // Command fields, stable while cmd_req is high
  always_ff @(posedge clk) begin
    if (take_op) begin
      cmd.op   <= byte_op;
      cmd.addr <= rx_byte[3:0];
      cmd.data <= '0;
    end
    if (take_data) begin
      cmd.data <= rx_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_OP;
      rx_ack    <= 1'b0;
      cmd_req   <= 1'b0;
      need_data <= 1'b0;
    end else begin
      case (state)
        S_OP: begin
          if (rx_req) begin
            rx_ack    <= 1'b1;
            need_data <= op_has_data(byte_op);
            state     <= S_REL;
          end
        end

        S_DATA: begin
          if (rx_req) begin
            rx_ack    <= 1'b1;
            need_data <= 1'b0;  // Operand is the last byte
            state     <= S_REL;
          end
        end

        S_REL: begin
          if (!rx_req) begin
            rx_ack <= 1'b0;
            state  <= need_data ? S_DATA : S_ISSUE;
          end
        end

        // Byte link fully released one cycle ago
        S_ISSUE: begin
          cmd_req <= 1'b1;
          state   <= S_CMD;
        end

        S_CMD: begin
          if (cmd_ack) begin
            cmd_req <= 1'b0;
            state   <= S_CMD_REL;
          end
        end

        S_CMD_REL: begin
          if (!cmd_ack) begin
            state <= S_OP;  // Ready for the next command
          end
        end

        default: state <= S_OP;
      endcase
    end
  end

endmodule

// File: design/reg_engine.sv
`timescale 1ns/100ps

module reg_engine (
  input  logic               clk,
  input  logic               reset,
  input  uart_cmd_pkg::cmd_t cmd,
  input  logic               cmd_req,
  output logic               cmd_ack,
  output logic [7:0]         resp_byte,
  output logic               resp_req,
  input  logic               resp_ack
);

  import uart_cmd_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACK,   // Command taken, waiting for cmd_req to drop
    S_RESP,  // Response presented
    S_REL    // Waiting for resp_ack to drop
  } eng_state_e;

  eng_state_e state;
  logic [7:0] regs [NUM_REGS];
  logic [7:0] cur_val;
  logic [7:0] result;
  logic       wr_en;
  logic       exec;

  assign cur_val = regs[cmd.addr];

  // Only taken from idle, so the response link is always free here
  assign exec = (state == S_IDLE) && cmd_req;

  always_comb begin
    result = RESP_ERR;
    wr_en  = 1'b0;
    case (cmd.op)
      OP_READ: begin
        result = cur_val;
      end
      OP_WRITE: begin
        result = cmd.data;
        wr_en  = 1'b1;
      end
      OP_ADD: begin
        result = cur_val + cmd.data;  // Wraps modulo 256
        wr_en  = 1'b1;
      end
      OP_XOR: begin
        result = cur_val ^ cmd.data;
        wr_en  = 1'b1;
      end
      default: begin
        result = RESP_ERR;  // Unknown opcode, bank untouched
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (exec && wr_en) begin
      regs[cmd.addr] <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (exec) begin
      resp_byte <= result;  // Held until the next command
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      cmd_ack  <= 1'b0;
      resp_req <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_req) begin
            cmd_ack <= 1'b1;
            state   <= S_ACK;
          end
        end
        S_ACK: begin
          if (!cmd_req) begin
            cmd_ack  <= 1'b0;
            resp_req <= 1'b1;
            state    <= S_RESP;
          end
        end
        S_RESP: begin
          if (resp_ack) begin
            resp_req <= 1'b0;
            state    <= S_REL;
          end
        end
        S_REL: begin
          if (!resp_ack) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: design/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // Serial bit timing, kept short for simulation
  localparam int CLKS_PER_BIT = 16;
  localparam int CNT_W        = $clog2(CLKS_PER_BIT);  // Bit-timing counter width

  // Register bank
  localparam int NUM_REGS = 16;

  // Response byte for an opcode the engine does not know
  localparam logic [7:0] RESP_ERR = 8'hEE;

  // Opcodes carried in bits 7:4 of the first command byte
  typedef enum logic [3:0] {
    OP_READ  = 4'd1,  // One byte, returns register
    OP_WRITE = 4'd2,
    OP_ADD   = 4'd3,
    OP_XOR   = 4'd4
  } cmd_op_e;

  // Complete command as handed from the assembler to the engine
  typedef struct packed {
    cmd_op_e    op;
    logic [3:0] addr;
    logic [7:0] data;  // Operand, zero for one-byte commands
  } cmd_t;

  // True for opcodes that are followed by an operand byte
  function automatic logic op_has_data(cmd_op_e op);
    case (op)
      OP_WRITE,
      OP_ADD,
      OP_XOR:  return 1'b1;
      default: return 1'b0;  // Read and unknown opcodes
    endcase
  endfunction

endpackage

// File: design/uart_cmd_top.sv
`timescale 1ns/100ps

module uart_cmd_top (
  input  logic clk,
  input  logic reset,
  input  logic rx_serial,
  output logic tx_serial
);

  import uart_cmd_pkg::*;

  // Receiver to assembler
  logic [7:0] rx_byte;
  logic       rx_req;
  logic       rx_ack;

  // Assembler to register engine
  cmd_t       cmd;
  logic       cmd_req;
  logic       cmd_ack;

  // Register engine to transmitter
  logic [7:0] resp_byte;
  logic       resp_req;
  logic       resp_ack;

  uart_rx u_uart_rx (
    .clk     (clk),
    .reset   (reset),
    .serial  (rx_serial),
    .rx_byte (rx_byte),
    .rx_req  (rx_req),
    .rx_ack  (rx_ack)
  );

  cmd_assembler u_cmd_assembler (
    .clk     (clk),
    .reset   (reset),
    .rx_byte (rx_byte),
    .rx_req  (rx_req),
    .rx_ack  (rx_ack),
    .cmd     (cmd),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack)
  );

  reg_engine u_reg_engine (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .resp_byte (resp_byte),
    .resp_req  (resp_req),
    .resp_ack  (resp_ack)
  );

  // One response frame per command
  uart_tx u_uart_tx (
    .clk       (clk),
    .reset     (reset),
    .resp_byte (resp_byte),
    .resp_req  (resp_req),
    .resp_ack  (resp_ack),
    .serial    (tx_serial)
  );

endmodule

// File: design/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
  input  logic       clk,
  input  logic       reset,
  input  logic       serial,
  output logic [7:0] rx_byte,
  output logic       rx_req,
  input  logic       rx_ack
);

  import uart_cmd_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP,
    S_WAIT
  } rx_state_e;

  rx_state_e        state;
  logic             serial_meta;
  logic             serial_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       rx_shift;
  logic             bit_end;
  logic             sample_data;
  logic             frame_ok;

  // Two-flop synchronizer, the line idles high
  always_ff @(posedge clk) begin
    if (reset) begin
      serial_meta <= 1'b1;
      serial_sync <= 1'b1;
    end else begin
      serial_meta <= serial;
      serial_sync <= serial_meta;
    end
  end

  assign bit_end     = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign sample_data = (state == S_DATA) && bit_end;

  // Good stop bit and a free link, otherwise the byte is lost
  assign frame_ok = (state == S_STOP) && bit_end && serial_sync && !rx_req && !rx_ack;

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample_data) begin
      rx_shift <= {serial_sync, rx_shift[7:1]};
    end
    if (frame_ok) begin
      rx_byte <= rx_shift;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      rx_req  <= 1'b0;
    end else begin
      if (rx_req && rx_ack) begin
        rx_req <= 1'b0;  // Sender side release
      end
      if (frame_ok) begin
        rx_req <= 1'b1;
      end

      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!serial_sync) begin
            state <= S_START;  // Falling start edge
          end
        end

        // Still low at mid-bit, otherwise it was a glitch
        S_START: begin
          if (clk_cnt == CNT_W'((CLKS_PER_BIT - 1) / 2)) begin
            clk_cnt <= '0;
            state   <= serial_sync ? S_IDLE : S_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        S_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= S_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        S_STOP: begin
          if (bit_end) begin
            clk_cnt <= '0;
            state   <= S_WAIT;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        // Hold off until the line is high again, covers a low stop bit
        S_WAIT: begin
          if (serial_sync) begin
            state <= S_IDLE;
          end
        end

        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] resp_byte,
  input  logic       resp_req,
  output logic       resp_ack,
  output logic       serial
);

  import uart_cmd_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP,
    S_REL
  } tx_state_e;

  tx_state_e        state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       tx_shift;
  logic             bit_end;
  logic             load;

  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign load    = (state == S_IDLE) && resp_req && !resp_ack;

  // Bit 0 of the shifter is always the data bit on the line
  always_ff @(posedge clk) begin
    if (load) begin
      tx_shift <= resp_byte;
    end else if ((state == S_DATA) && bit_end) begin
      tx_shift <= tx_shift >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      resp_ack <= 1'b0;
      serial   <= 1'b1;  // Idle line
    end else begin
      if (resp_ack && !resp_req) begin
        resp_ack <= 1'b0;
      end

      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (load) begin
            resp_ack <= 1'b1;
            serial   <= 1'b0;  // Start bit begins with the ack
            state    <= S_START;
          end
        end

        S_START: begin
          if (bit_end) begin
            clk_cnt <= '0;
            serial  <= tx_shift[0];
            state   <= S_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        S_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              serial <= 1'b1;  // Stop bit
              state  <= S_STOP;
            end else begin
              serial <= tx_shift[1];  // Next bit, shifter moves this edge
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        S_STOP: begin
          if (bit_end) begin
            clk_cnt <= '0;
            state   <= S_REL;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        // Frame done, take no byte until the link is released
        S_REL: begin
          if (!resp_ack) begin
            state <= S_IDLE;
          end
        end

        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: testbench/tb_uart_cmd_top.sv
`timescale 1ns/100ps

module tb_uart_cmd_top;

  import uart_cmd_pkg::*;

  // Frames in tests 2 to 5, with every random command counted as two bytes
  localparam int FRAMES_SENT = 132;
  localparam int FRAMES_RESP = 75;
  localparam int MAX_CYCLES  = (FRAMES_SENT + FRAMES_RESP) * 12 * CLKS_PER_BIT + 2000;

  logic        clk;
  logic        reset;
  logic        rx_serial;
  logic        tx_serial;

  logic [7:0]  model_regs [16];  // Reference register bank
  logic [7:0]  exp_q [$];        // Expected responses in order
  logic [7:0]  recv_q [$];       // Bytes decoded from tx_serial
  logic [31:0] rng_state = 32'd7;
  int          fail_cnt  = 0;
  int          test_pass = 0;
  int          test_fail = 0;
  int          cycle_cnt = 0;

  uart_cmd_top u_uart_cmd_top (
    .clk       (clk),
    .reset     (reset),
    .rx_serial (rx_serial),
    .tx_serial (tx_serial)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Applies one command to the model and returns the response byte
  function automatic logic [7:0] model_exec(input logic [3:0] op, input logic [3:0] addr,
                                            input logic [7:0] data);
    logic [7:0] val;
    val = model_regs[addr];
    case (op)
      OP_READ:  return val;
      OP_WRITE: model_regs[addr] = data;
      OP_ADD:   model_regs[addr] = val + data;  // Modulo 256
      OP_XOR:   model_regs[addr] = val ^ data;
      default:  return RESP_ERR;
    endcase
    return model_regs[addr];
  endfunction

  // One 8N1 frame followed by one idle bit, stop level selectable
  task automatic send_frame(input logic [7:0] value, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx_serial = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    rx_serial = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic send_cmd(input logic [3:0] op, input logic [3:0] addr, input logic [7:0] data);
    send_frame({op, addr}, 1'b1);
    if (op == OP_WRITE || op == OP_ADD || op == OP_XOR) begin
      send_frame(data, 1'b1);  // Operand byte
    end
    exp_q.push_back(model_exec(op, addr, data));
  endtask

  // Pairs every expected byte with the next decoded one
  task automatic check_responses();
    logic [7:0] got;
    logic [7:0] want;
    while (exp_q.size() > 0) begin
      while (recv_q.size() == 0) begin
        @(negedge clk);
      end
      got  = recv_q.pop_front();
      want = exp_q.pop_front();
      assert (got === want) else begin
        $display("error at %0t ns: resp_byte expected %02h, received %02h", $time, want, got);
        fail_cnt++;
      end
    end
  endtask

  task automatic report_test(input int num, input string name, input int fails_before);
    if (fail_cnt == fails_before) begin
      $display("test %0d %s: ok", num, name);
      test_pass++;
    end else begin
      $display("test %0d %s: %0d errors", num, name, fail_cnt - fails_before);
      test_fail++;
    end
  endtask

  // Samples each bit of a response frame at mid-bit
  task automatic monitor_frame();
    logic [7:0] value;
    @(negedge tx_serial);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    assert (tx_serial === 1'b0) else begin
      $display("start bit on tx_serial did not stay low to mid-bit at %0t ns", $time);
      fail_cnt++;
    end
    if (tx_serial === 1'b0) begin
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        value[i] = tx_serial;  // LSB first
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      assert (tx_serial === 1'b1) else begin
        $display("response frame on tx_serial ended with a low stop bit at %0t ns", $time);
        fail_cnt++;
      end
      recv_q.push_back(value);
    end
  endtask

  initial begin
    forever begin
      monitor_frame();
    end
  end

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run timed out after %0d cycles with responses still missing", cycle_cnt);
    $display("sim failed");
    $finish;
  end

  initial begin
    int          fails_before;
    logic [31:0] r;
    logic [3:0]  op;
    logic [3:0]  addr;
    reset     = 1'b1;
    rx_serial = 1'b1;
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = 8'h00;
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // Quiet line after reset
    fails_before = fail_cnt;
    repeat (20 * CLKS_PER_BIT) begin
      @(negedge clk);
      assert (tx_serial === 1'b1) else begin
        $display("error at %0t ns: tx_serial expected 1, received %b", $time, tx_serial);
        fail_cnt++;
      end
    end
    assert (recv_q.size() == 0) else begin
      $display("a response frame appeared on tx_serial with no command sent");
      fail_cnt++;
    end
    report_test(1, "idle line after reset", fails_before);

    fails_before = fail_cnt;
    for (int a = 0; a < 16; a++) begin
      r = xorshift();
      send_cmd(OP_WRITE, 4'(a), r[7:0]);
      send_cmd(OP_READ, 4'(a), 8'h00);
    end
    check_responses();
    report_test(2, "write then read all registers", fails_before);

    // Back to back random commands
    fails_before = fail_cnt;
    repeat (40) begin
      r  = xorshift();
      op = 4'd1 + 4'(r[1:0]);
      send_cmd(op, r[7:4], r[15:8]);
    end
    check_responses();
    report_test(3, "random commands", fails_before);

    fails_before = fail_cnt;
    r  = xorshift();
    op = r[3:0];
    if (op >= 4'd1 && op <= 4'd4) begin
      op = op + 4'd8;  // Move into the unknown range
    end
    addr = r[7:4];
    send_cmd(op, addr, 8'h00);
    send_cmd(OP_READ, addr, 8'h00);
    check_responses();
    report_test(4, "unknown opcode", fails_before);

    // A read framed with a low stop bit must vanish
    fails_before = fail_cnt;
    r    = xorshift();
    addr = r[3:0];
    send_frame({OP_READ, r[7:4]}, 1'b0);
    send_cmd(OP_READ, addr, 8'h00);
    check_responses();
    repeat (15 * CLKS_PER_BIT) @(negedge clk);
    assert (recv_q.size() == 0) else begin
      $display("an extra response byte arrived after the frame with a low stop bit");
      fail_cnt++;
    end
    report_test(5, "low stop bit frame dropped", fails_before);

    $display("tests passed %0d, failed %0d, errors %0d", test_pass, test_fail, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: uart_cmd_top.f
design/uart_cmd_pkg.sv
design/uart_rx.sv
design/cmd_assembler.sv
design/reg_engine.sv
design/uart_tx.sv
design/uart_cmd_top.sv
testbench/tb_uart_cmd_top.sv
